/* lane_pkg.sv */
// ******************************
// Lane operand path package
// Widths, enums, command struct
// ******************************
package lane_pkg;

  // Datapath and VRF geometry
  localparam int unsigned ElenWidth  = 64;
  localparam int unsigned ElenBytes  = ElenWidth / 8;
  localparam int unsigned VAddrWidth = 6;
  localparam int unsigned NrVrfWords = 2 ** VAddrWidth;
  localparam int unsigned VlenWidth  = 9;

  typedef logic [ElenWidth-1:0]  elen_t;
  typedef logic [VAddrWidth-1:0] vaddr_t;
  typedef logic [VlenWidth-1:0]  vlen_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } ew_e;

  // Widening applied by the operand queue
  typedef enum logic [2:0] {
    ConvNone, ConvSExt2, ConvSExt4, ConvSExt8, ConvZExt2, ConvZExt4, ConvZExt8
  } conv_e;

  // Shared by requester, queue and command FIFO
  typedef struct packed {
    vaddr_t base;
    vlen_t  vl;
    ew_e    eew;
    conv_e  conv;
  } opq_cmd_t;

  // Elements of width ew held by one VRF word
  function automatic logic [3:0] ElemPerWord(ew_e ew);
    return 4'(ElenBytes) >> ew;
  endfunction

endpackage

/* fifo_buf.sv */
// ******************************
// Generic FWFT FIFO
// ******************************
module fifo_buf #(
  parameter int unsigned Depth  = 2,
  parameter type         data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output data_t data_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  data_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push, do_pop;

  // Step a pointer around the ring
  function automatic logic [PtrWidth-1:0] next_ptr(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));
  // A push into a full FIFO only lands when the head leaves
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || pop_i);

  // Head entry visible without a pop
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      // Occupancy only moves when one side acts alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* vrf_bank.sv */
// ******************************
// Single-port VRF memory
// ******************************
module vrf_bank (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             we_i,
  input  lane_pkg::vaddr_t waddr_i,
  input  lane_pkg::elen_t  wdata_i,
  input  logic             re_i,
  input  lane_pkg::vaddr_t raddr_i,
  output lane_pkg::elen_t  rdata_o
);

  lane_pkg::elen_t mem_q [lane_pkg::NrVrfWords];

  // External load port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // One-cycle read, dropped while a load is in progress
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (re_i && !we_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

/* vrf_arbiter.sv */
// ******************************
// Round-robin VRF read arbiter
// ******************************
module vrf_arbiter #(
  parameter int unsigned NrQueues = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [NrQueues-1:0]   req_i,
  input  lane_pkg::vaddr_t      addr_i [NrQueues],
  output logic [NrQueues-1:0]   gnt_o,
  output logic [NrQueues-1:0]   rvalid_o,
  output logic                  re_o,
  output lane_pkg::vaddr_t      raddr_o
);

  localparam int unsigned IdxWidth = (NrQueues > 1) ? $clog2(NrQueues) : 1;

  // Highest priority requester for this cycle
  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] win_idx;

  always_comb begin : arbitrate
    int unsigned idx;
    logic        found;
    gnt_o   = '0;
    win_idx = '0;
    found   = 1'b0;
    // Scan from the pointer, wrapping around
    for (int i = 0; i < NrQueues; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= NrQueues) idx = idx - NrQueues;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        win_idx    = IdxWidth'(idx);
        gnt_o[idx] = 1'b1;
      end
    end
  end

  // Single read port of the VRF
  assign re_o    = |req_i;
  assign raddr_o = addr_i[win_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q    <= '0;
      rvalid_o <= '0;
    end else begin
      // Data returns next cycle to the winner
      rvalid_o <= gnt_o;
      // Next search starts after the last winner
      if (re_o) begin
        ptr_q <= (win_idx == IdxWidth'(NrQueues - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

endmodule

/* operand_requester.sv */
// ******************************
// Operand requester
// Word count and VRF addressing
// ******************************
module operand_requester (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lane_pkg::opq_cmd_t cmd_i,
  input  logic               cmd_valid_i,
  input  logic               queue_ready_i,
  input  logic               gnt_i,
  output logic               req_o,
  output lane_pkg::vaddr_t   addr_o
);

  // Active command state
  lane_pkg::vaddr_t   addr_q;
  lane_pkg::vlen_t    words_left_q;
  // One command waiting behind the active one
  lane_pkg::opq_cmd_t pend_q;
  logic               pend_valid_q;

  lane_pkg::opq_cmd_t next_cmd;
  logic               can_load;
  logic               last_gnt;
  logic [lane_pkg::VlenWidth:0] round_vl;
  lane_pkg::vlen_t    next_words;

  assign last_gnt = gnt_i && (words_left_q == lane_pkg::vlen_t'(1));
  assign can_load = (words_left_q == '0) || last_gnt;
  // Older pending command goes first
  assign next_cmd = pend_valid_q ? pend_q : cmd_i;

  // Source words = ceil(vl / elements per word)
  assign round_vl   = {1'b0, next_cmd.vl} +
                      (lane_pkg::VlenWidth + 1)'(lane_pkg::ElemPerWord(next_cmd.eew) - 1'b1);
  assign next_words = lane_pkg::vlen_t'(round_vl >> (2'd3 - next_cmd.eew));

  assign req_o  = (words_left_q != '0) && queue_ready_i;
  assign addr_o = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q       <= '0;
      words_left_q <= '0;
      pend_valid_q <= 1'b0;
      pend_q       <= '0;
    end else begin
      // Step through the vector on each grant
      if (gnt_i) begin
        addr_q       <= addr_q + 1'b1;
        words_left_q <= words_left_q - 1'b1;
      end
      if (can_load && (pend_valid_q || cmd_valid_i)) begin
        addr_q       <= next_cmd.base;
        words_left_q <= next_words;
        // A strobe during a pending load takes the freed slot
        pend_valid_q <= pend_valid_q && cmd_valid_i;
        if (pend_valid_q) pend_q <= cmd_i;
      end else if (cmd_valid_i) begin
        pend_valid_q <= 1'b1;
        pend_q       <= cmd_i;
      end
    end
  end

endmodule

/* operand_queue.sv */
// ******************************
// Operand queue
// Credit count, widening, count
// ******************************
module operand_queue #(
  parameter int unsigned BufferDepth = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lane_pkg::opq_cmd_t cmd_i,
  input  logic               cmd_valid_i,
  input  lane_pkg::elen_t    operand_i,
  input  logic               operand_valid_i,
  input  logic               operand_issued_i,
  output logic               operand_queue_ready_o,
  output lane_pkg::elen_t    operand_o,
  output logic               operand_valid_o,
  input  logic               operand_ready_i
);

  localparam int unsigned UsageWidth = $clog2(BufferDepth + 1);

  lane_pkg::opq_cmd_t cmd;
  logic               cmd_empty;
  logic               cmd_pop;

  fifo_buf #(
    .Depth  (BufferDepth),
    .data_t (lane_pkg::opq_cmd_t)
  ) i_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_i),
    .pop_i   (cmd_pop),
    .data_o  (cmd),
    .empty_o (cmd_empty),
    .full_o  ()
  );

  lane_pkg::elen_t ibuf_word;
  logic            ibuf_empty;
  logic            ibuf_pop;

  fifo_buf #(
    .Depth  (BufferDepth),
    .data_t (lane_pkg::elen_t)
  ) i_word_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (ibuf_pop),
    .data_o  (ibuf_word),
    .empty_o (ibuf_empty),
    .full_o  ()
  );

  // Words issued to the VRF and not yet popped
  logic [UsageWidth-1:0] usage_q;

  assign operand_queue_ready_o = (usage_q < UsageWidth'(BufferDepth));

  // Conversion decode: log2 of the factor and extension kind
  logic [1:0] fact_log;
  logic       sext;
  logic [2:0] dst_log;

  always_comb begin
    fact_log = 2'd0;
    sext     = 1'b0;
    unique case (cmd.conv)
      lane_pkg::ConvSExt2: {sext, fact_log} = {1'b1, 2'd1};
      lane_pkg::ConvSExt4: {sext, fact_log} = {1'b1, 2'd2};
      lane_pkg::ConvSExt8: {sext, fact_log} = {1'b1, 2'd3};
      lane_pkg::ConvZExt2: fact_log = 2'd1;
      lane_pkg::ConvZExt4: fact_log = 2'd2;
      lane_pkg::ConvZExt8: fact_log = 2'd3;
      default:             fact_log = 2'd0;
    endcase
  end

  // Destination width as log2 of its bytes
  assign dst_log = {1'b0, cmd.eew} + {1'b0, fact_log};

  // Byte offset of the next source element in the head word
  logic [2:0]      select_d, select_q;
  // Elements already handed out for the head command
  lane_pkg::vlen_t cnt_d, cnt_q;
  lane_pkg::elen_t conv_operand;

  always_comb begin : widen
    logic [2:0] db;
    logic [2:0] de_base;
    logic [2:0] src_byte;
    logic [2:0] msb_byte;
    conv_operand = '0;
    // Build each output byte from a source byte or the fill
    for (int b = 0; b < lane_pkg::ElenBytes; b++) begin
      db       = 3'(b) & ((3'd1 << dst_log) - 3'd1);
      de_base  = (3'(b) >> dst_log) << cmd.eew;
      src_byte = select_q + de_base + db;
      msb_byte = select_q + de_base + ((3'd1 << cmd.eew) - 3'd1);
      if ({1'b0, db} < (4'd1 << cmd.eew)) begin
        conv_operand[8*b +: 8] = ibuf_word[8*src_byte +: 8];
      end else if (sext) begin
        conv_operand[8*b +: 8] = {8{ibuf_word[8*msb_byte + 7]}};
      end
    end
  end

  assign operand_o       = conv_operand;
  assign operand_valid_o = !ibuf_empty && !cmd_empty;

  always_comb begin : out_ctrl
    ibuf_pop = 1'b0;
    cmd_pop  = 1'b0;
    select_d = select_q;
    cnt_d    = cnt_q;
    if (operand_valid_o && operand_ready_i) begin
      cnt_d    = cnt_q + lane_pkg::vlen_t'(lane_pkg::ElemPerWord(lane_pkg::ew_e'(dst_log[1:0])));
      // Source bytes used per operand, a full word wraps to zero
      select_d = select_q + 3'(4'(lane_pkg::ElenBytes) >> fact_log);
      if (select_d == '0) ibuf_pop = 1'b1;
      // Last operand of the command
      if (cnt_d >= cmd.vl) begin
        ibuf_pop = 1'b1;
        cmd_pop  = 1'b1;
        select_d = '0;
        cnt_d    = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usage_q  <= '0;
      select_q <= '0;
      cnt_q    <= '0;
    end else begin
      usage_q  <= usage_q + UsageWidth'(operand_issued_i) - UsageWidth'(ibuf_pop);
      select_q <= select_d;
      cnt_q    <= cnt_d;
    end
  end

endmodule

/* lane_operand_top.sv */
// ******************************
// Lane operand delivery top
// ******************************
module lane_operand_top #(
  parameter int unsigned NrQueues    = 2,
  parameter int unsigned BufferDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_pkg::opq_cmd_t   cmd_i [NrQueues],
  input  logic [NrQueues-1:0]  cmd_valid_i,
  input  logic [NrQueues-1:0]  operand_ready_i,
  output lane_pkg::elen_t      operand_o [NrQueues],
  output logic [NrQueues-1:0]  operand_valid_o,
  input  logic                 vrf_we_i,
  input  lane_pkg::vaddr_t     vrf_waddr_i,
  input  lane_pkg::elen_t      vrf_wdata_i
);

  logic [NrQueues-1:0] req;
  logic [NrQueues-1:0] gnt;
  logic [NrQueues-1:0] rvalid;
  logic [NrQueues-1:0] queue_ready;
  lane_pkg::vaddr_t    req_addr [NrQueues];
  logic                vrf_re;
  lane_pkg::vaddr_t    vrf_raddr;
  lane_pkg::elen_t     vrf_rdata;

  vrf_bank i_vrf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (vrf_we_i),
    .waddr_i (vrf_waddr_i),
    .wdata_i (vrf_wdata_i),
    .re_i    (vrf_re),
    .raddr_i (vrf_raddr),
    .rdata_o (vrf_rdata)
  );

  vrf_arbiter #(
    .NrQueues (NrQueues)
  ) i_arbiter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req),
    .addr_i   (req_addr),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .re_o     (vrf_re),
    .raddr_o  (vrf_raddr)
  );

  // One requester and queue per operand stream
  for (genvar q = 0; q < NrQueues; q++) begin : g_queue
    operand_requester i_requester (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .cmd_i         (cmd_i[q]),
      .cmd_valid_i   (cmd_valid_i[q]),
      .queue_ready_i (queue_ready[q]),
      .gnt_i         (gnt[q]),
      .req_o         (req[q]),
      .addr_o        (req_addr[q])
    );

    // Grant doubles as the credit issue strobe
    operand_queue #(
      .BufferDepth (BufferDepth)
    ) i_queue (
      .clk_i                 (clk_i),
      .rst_ni                (rst_ni),
      .cmd_i                 (cmd_i[q]),
      .cmd_valid_i           (cmd_valid_i[q]),
      .operand_i             (vrf_rdata),
      .operand_valid_i       (rvalid[q]),
      .operand_issued_i      (gnt[q]),
      .operand_queue_ready_o (queue_ready[q]),
      .operand_o             (operand_o[q]),
      .operand_valid_o       (operand_valid_o[q]),
      .operand_ready_i       (operand_ready_i[q])
    );
  end

endmodule

/* tb_lane_operand.sv */
// ******************************
// Directed testbench, lane operand path
// Reference model, LFSR ready, watchdog
// ******************************
module tb_lane_operand;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NrQueues    = 2;
  localparam int unsigned BufferDepth = 2;
  localparam int          NrCmds      = 8;
  localparam int          NrTests     = 5;
  localparam int          MaxOps      = 64;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  lane_pkg::opq_cmd_t   cmd_i [NrQueues];
  logic [NrQueues-1:0]  cmd_valid_i;
  logic [NrQueues-1:0]  operand_ready_i;
  lane_pkg::elen_t      operand_o [NrQueues];
  logic [NrQueues-1:0]  operand_valid_o;
  logic                 vrf_we_i;
  lane_pkg::vaddr_t     vrf_waddr_i;
  lane_pkg::elen_t      vrf_wdata_i;

  // Testbench copy of the VRF contents
  lane_pkg::elen_t vrf_copy [lane_pkg::NrVrfWords];
  // Expected operand streams, one per queue
  lane_pkg::elen_t exp_ops [NrQueues][MaxOps];
  int              exp_cnt [NrQueues] = '{0, 0};
  logic [15:0]     lfsr_q;

  // Commands used by the tests, indexed by test
  lane_pkg::opq_cmd_t cmd_tab [NrCmds] = '{
    '{base: 6'd0,  vl: 9'd5,  eew: lane_pkg::EW64, conv: lane_pkg::ConvNone},
    '{base: 6'd8,  vl: 9'd21, eew: lane_pkg::EW8,  conv: lane_pkg::ConvNone},
    '{base: 6'd16, vl: 9'd7,  eew: lane_pkg::EW32, conv: lane_pkg::ConvSExt2},
    '{base: 6'd24, vl: 9'd10, eew: lane_pkg::EW16, conv: lane_pkg::ConvSExt4},
    '{base: 6'd32, vl: 9'd13, eew: lane_pkg::EW8,  conv: lane_pkg::ConvZExt2},
    '{base: 6'd40, vl: 9'd11, eew: lane_pkg::EW8,  conv: lane_pkg::ConvZExt8},
    '{base: 6'd48, vl: 9'd17, eew: lane_pkg::EW16, conv: lane_pkg::ConvSExt2},
    '{base: 6'd56, vl: 9'd19, eew: lane_pkg::EW8,  conv: lane_pkg::ConvZExt4}
  };

  lane_operand_top #(
    .NrQueues    (NrQueues),
    .BufferDepth (BufferDepth)
  ) uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .operand_ready_i (operand_ready_i),
    .operand_o       (operand_o),
    .operand_valid_o (operand_valid_o),
    .vrf_we_i        (vrf_we_i),
    .vrf_waddr_i     (vrf_waddr_i),
    .vrf_wdata_i     (vrf_wdata_i)
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // log2 of the widening factor
  function automatic int factor_log(input lane_pkg::conv_e conv);
    case (conv)
      lane_pkg::ConvSExt2, lane_pkg::ConvZExt2: return 1;
      lane_pkg::ConvSExt4, lane_pkg::ConvZExt4: return 2;
      lane_pkg::ConvSExt8, lane_pkg::ConvZExt8: return 3;
      default: return 0;
    endcase
  endfunction

  function automatic bit sign_extends(input lane_pkg::conv_e conv);
    return conv inside {lane_pkg::ConvSExt2, lane_pkg::ConvSExt4, lane_pkg::ConvSExt8};
  endfunction

  // Operands = ceil(vl / elements per destination word)
  function automatic int ops_for(input lane_pkg::opq_cmd_t cmd);
    int per_op;
    per_op = 8 >> (int'(cmd.eew) + factor_log(cmd.conv));
    return (int'(cmd.vl) + per_op - 1) / per_op;
  endfunction

  // Every byte mixes the full word address
  function automatic lane_pkg::elen_t fill_word(input int addr, input logic [7:0] salt);
    lane_pkg::elen_t w;
    for (int k = 0; k < 8; k++) begin
      w[8*k +: 8] = 8'(addr * 37 + k * 91) ^ salt;
    end
    return w;
  endfunction

  task automatic load_vrf(input logic [7:0] salt);
    lane_pkg::elen_t data;
    for (int a = 0; a < lane_pkg::NrVrfWords; a++) begin
      data = fill_word(a, salt);
      @(posedge clk_i);
      vrf_we_i    <= 1'b1;
      vrf_waddr_i <= lane_pkg::vaddr_t'(a);
      vrf_wdata_i <= data;
      vrf_copy[a] = data;
    end
    @(posedge clk_i);
    vrf_we_i <= 1'b0;
  endtask

  // Widening model, elements packed in order from the base word
  task automatic add_expected(input int q, input lane_pkg::opq_cmd_t cmd);
    int                 sb, fl, db, n, s, elems;
    lane_pkg::vaddr_t   addr;
    lane_pkg::elen_t    word, op;
    logic signed [63:0] v;
    sb    = 1 << int'(cmd.eew);
    fl    = factor_log(cmd.conv);
    db    = sb << fl;
    n     = 8 / db;
    addr  = cmd.base;
    s     = 0;
    elems = 0;
    while (elems < int'(cmd.vl)) begin
      word = vrf_copy[addr];
      op   = '0;
      for (int j = 0; j < n; j++) begin
        // Element to the top, then back down with the chosen fill
        v = word >> (8 * (s + j * sb));
        v = v << (64 - 8 * sb);
        if (sign_extends(cmd.conv)) v = v >>> (64 - 8 * sb);
        else v = v >> (64 - 8 * sb);
        if (db < 8) v = v & ((64'd1 << (8 * db)) - 64'd1);
        op = op | (lane_pkg::elen_t'(v) << (8 * j * db));
      end
      exp_ops[q][exp_cnt[q]] = op;
      exp_cnt[q]++;
      elems += n;
      // Source bytes taken per operand
      s += 8 >> fl;
      if (s == 8) begin
        s    = 0;
        addr = addr + 1'b1;
      end
    end
  endtask

  // Strobe commands on the selected queues in one cycle
  task automatic issue_cmds(input logic [1:0] sel, input int idx0, input int idx1);
    @(posedge clk_i);
    cmd_valid_i <= sel;
    if (sel[0]) begin
      cmd_i[0] <= cmd_tab[idx0];
      add_expected(0, cmd_tab[idx0]);
    end
    if (sel[1]) begin
      cmd_i[1] <= cmd_tab[idx1];
      add_expected(1, cmd_tab[idx1]);
    end
  endtask

  // Drive ready, sample at the falling edge, compare against the model
  task automatic collect_streams(input string name, input bit random_ready);
    int              idx [NrQueues];
    logic            held_valid [NrQueues];
    lane_pkg::elen_t held_data [NrQueues];
    idx        = '{0, 0};
    held_valid = '{1'b0, 1'b0};
    while (idx[0] < exp_cnt[0] || idx[1] < exp_cnt[1]) begin
      @(posedge clk_i);
      cmd_valid_i <= '0;
      for (int q = 0; q < NrQueues; q++) begin
        if (random_ready) begin
          lfsr_q = lfsr_next(lfsr_q);
          operand_ready_i[q] <= lfsr_q[0];
        end else begin
          operand_ready_i[q] <= 1'b1;
        end
      end
      @(negedge clk_i);
      for (int q = 0; q < NrQueues; q++) begin
        // A stalled operand must stay put
        if (held_valid[q]) begin
          assert (operand_valid_o[q] && operand_o[q] === held_data[q])
            else stop_on_error($sformatf("%s: queue %0d changed its operand while stalled",
                                         name, q));
        end
        held_valid[q] = 1'b0;
        if (operand_valid_o[q]) begin
          assert (idx[q] < exp_cnt[q])
            else stop_on_error($sformatf("%s: queue %0d gave more operands than expected",
                                         name, q));
          if (operand_ready_i[q]) begin
            assert (operand_o[q] === exp_ops[q][idx[q]])
              else stop_on_error($sformatf(
                "mismatch in %s: queue %0d operand %0d expected %h actual %h",
                name, q, idx[q], exp_ops[q][idx[q]], operand_o[q]));
            idx[q]++;
          end else begin
            held_valid[q] = 1'b1;
            held_data[q]  = operand_o[q];
          end
        end
      end
    end
    @(posedge clk_i);
    operand_ready_i <= '0;
    // Nothing left over once the streams are done
    repeat (3) begin
      @(negedge clk_i);
      assert (operand_valid_o == '0)
        else stop_on_error($sformatf("%s: an operand appeared after the last one", name));
    end
    exp_cnt = '{0, 0};
  endtask

  task automatic test_idle_after_reset();
    repeat (8) begin
      @(negedge clk_i);
      assert (operand_valid_o == '0)
        else stop_on_error("operand valid rose after reset with no command given");
    end
  endtask

  task automatic test_conv_none();
    load_vrf(8'h00);
    issue_cmds(2'b01, 0, 0);
    issue_cmds(2'b01, 1, 0);
    collect_streams("conv_none", 1'b0);
  endtask

  task automatic test_sign_extend();
    load_vrf(8'h5a);
    issue_cmds(2'b01, 2, 0);
    issue_cmds(2'b01, 3, 0);
    collect_streams("sign_extend", 1'b0);
  endtask

  task automatic test_zero_extend();
    load_vrf(8'hc3);
    issue_cmds(2'b01, 4, 0);
    issue_cmds(2'b01, 5, 0);
    collect_streams("zero_extend", 1'b0);
  endtask

  // Both queues at once under random back-pressure
  task automatic test_dual_queue();
    load_vrf(8'h96);
    issue_cmds(2'b11, 6, 7);
    collect_streams("dual_queue", 1'b1);
  endtask

  // Bound of 20 cycles per operand plus load and reset time
  initial begin : watchdog
    int total;
    total = 0;
    for (int i = 0; i < NrCmds; i++) begin
      total += ops_for(cmd_tab[i]);
    end
    repeat (total * 20 + NrTests * 80 + 40) @(posedge clk_i);
    stop_on_error("timeout, the tests did not finish in the expected time");
  end

  initial begin
    rst_ni          = 1'b0;
    cmd_i[0]        = '0;
    cmd_i[1]        = '0;
    cmd_valid_i     = '0;
    operand_ready_i = '0;
    vrf_we_i        = 1'b0;
    vrf_waddr_i     = '0;
    vrf_wdata_i     = '0;
    lfsr_q          = 16'd40;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_idle_after_reset();
    test_conv_none();
    test_sign_extend();
    test_zero_extend();
    test_dual_queue();
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* lane_operand.f */
lane_pkg.sv
fifo_buf.sv
vrf_bank.sv
vrf_arbiter.sv
operand_requester.sv
operand_queue.sv
lane_operand_top.sv
tb_lane_operand.sv
